/* Makefile */
# Simulator, flags, top module and file list
SIM       := verilator
SIMFLAGS  := --binary --timing -Wno-fatal
TOP       := tb_icache
FILELIST  := icache_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Available targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

# The run itself always completes, the log search decides pass or fail
test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/cache_data.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_data import cache_pkg::*; (
	input logic clk,
	input index_t rd_index_i,
	input logic wr_i,
	input way_t wr_way_i,
	input index_t wr_index_i,
	input line_t wr_line_i,
	output line_t [`CACHE_WAYS-1:0] lines_o
);

	// ======================================================================
	// Line storage
	// ======================================================================

	// Contents are only meaningful once a fill has written the matching tag
	line_t lines [`CACHE_WAYS][`CACHE_LINES];

	// Whole-line writes only, one way per fill
	always_ff @(posedge clk) begin
		if (wr_i) begin
			lines[wr_way_i][wr_index_i] <= wr_line_i;
		end
	end

	// All ways are read together so the lookup can pick the hitting one
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			lines_o[w] = lines[w][rd_index_i];
		end
	end

endmodule

/* hw/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ==========================================================================
// Instruction cache geometry
// ==========================================================================

// Number of sets held in each way
`define CACHE_LINES 64

// Associativity of the cache
`define CACHE_WAYS 4

// Address bit positions for 16-byte lines
`define CACHE_LOBIT 4
`define CACHE_HIBIT 9
`define CACHE_TAGBIT 10

// Tag value that marks an empty way, so addresses with this tag never hit
`define CACHE_INVALID_TAG 1

`endif

/* hw/cache_fill.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_fill import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic miss_i,
	input fetch_req_t miss_req_i,
	input way_t victim_i,
	input logic grant_i,
	input logic mem_ack_i,
	input line_t mem_line_i,
	output logic busy_o,
	output tag_wr_t wr_req_o,
	output logic mem_req_o,
	output address_t mem_adr_o,
	output logic data_wr_o,
	output way_t data_way_o,
	output index_t data_index_o,
	output line_t data_line_o,
	output logic valid_o,
	output logic [31:0] data_o
);

	// ======================================================================
	// Fill engine state
	// ======================================================================

	typedef enum logic [2:0] {
		S_SWEEP,
		S_IDLE,
		S_WAIT,
		S_WRITE,
		S_RETURN
	} state_e;

	state_e state;
	index_t sweep_idx;
	fetch_req_t req_q;
	way_t victim_q;
	line_t line_q;
	index_t fill_index;

	assign fill_index = req_q.vadr[`CACHE_HIBIT:`CACHE_LOBIT];

	// The sweep runs first after reset, then misses are served one at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_SWEEP;
			sweep_idx <= '0;
			mem_req_o <= 1'b0;
		end else begin
			mem_req_o <= 1'b0;
			case (state)
				S_SWEEP: begin
					if (grant_i) begin
						sweep_idx <= sweep_idx + 1'b1;
						if (sweep_idx == index_t'(`CACHE_LINES - 1)) begin
							state <= S_IDLE;
						end
					end
				end
				S_IDLE: begin
					if (miss_i) begin
						mem_req_o <= 1'b1;
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (mem_ack_i) begin
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (grant_i) begin
						state <= S_RETURN;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Request, victim and returned line are held for the whole miss
	always_ff @(posedge clk) begin
		if (state == S_IDLE && miss_i) begin
			req_q <= miss_req_i;
			victim_q <= victim_i;
			mem_adr_o <= {miss_req_i.padr[31:`CACHE_LOBIT], {`CACHE_LOBIT{1'b0}}};
		end
		if (state == S_WAIT && mem_ack_i) begin
			line_q <= mem_line_i;
		end
	end

	// ======================================================================
	// Tag and data writes
	// ======================================================================

	// The sweep asks for the port only once reset has been released
	always_comb begin
		wr_req_o = '0;
		if (state == S_SWEEP && !rst) begin
			wr_req_o.en = 1'b1;
			wr_req_o.kind = TAG_INVALIDATE;
			wr_req_o.index = sweep_idx;
		end else if (state == S_WRITE) begin
			wr_req_o.en = 1'b1;
			wr_req_o.kind = TAG_FILL;
			wr_req_o.way = victim_q;
			wr_req_o.index = fill_index;
			wr_req_o.vtag = req_q.vadr[31:`CACHE_TAGBIT];
			wr_req_o.ptag = req_q.padr[31:`CACHE_TAGBIT];
		end
	end

	// Line lands in the same cycle as its tags
	assign data_wr_o = (state == S_WRITE) & grant_i;
	assign data_way_o = victim_q;
	assign data_index_o = fill_index;
	assign data_line_o = line_q;

	// Busy covers the miss pulse itself so the next fetch is already held off
	assign busy_o = miss_i | (state == S_SWEEP) | (state == S_WAIT) | (state == S_WRITE);

	// Busy is already low while the word is returned
	assign valid_o = (state == S_RETURN);
	assign data_o = line_q[req_q.vadr[`CACHE_LOBIT-1:2]*32 +: 32];

endmodule

/* hw/cache_lookup.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_lookup import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch_i,
	input fetch_req_t fetch_req_i,
	input logic busy_i,
	input cache_tag_t [`CACHE_WAYS-1:0] vtags_i,
	input line_t [`CACHE_WAYS-1:0] line_i,
	output logic valid_o,
	output logic hit_o,
	output logic [31:0] data_o,
	output logic miss_o,
	output fetch_req_t miss_req_o,
	output logic touch_o,
	output way_t touch_way_o
);

	logic accept;
	logic hit_any;
	way_t hit_way;
	cache_tag_t fetch_tag;
	logic [1:0] word_sel;
	logic [31:0] hit_word;

	// Fetches that arrive while the fill engine is busy are dropped
	assign accept = fetch_i & ~busy_i;
	assign fetch_tag = fetch_req_i.vadr[31:`CACHE_TAGBIT];
	assign word_sel = fetch_req_i.vadr[`CACHE_LOBIT-1:2];

	// Empty ways hold the marker, which no cacheable address can match
	always_comb begin
		hit_any = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (vtags_i[w] == fetch_tag) begin
				hit_any = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	assign hit_word = line_i[hit_way][word_sel*32 +: 32];

	// Control outputs, hits answer here while misses go to the fill engine
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_o <= 1'b0;
			hit_o <= 1'b0;
			miss_o <= 1'b0;
			touch_o <= 1'b0;
		end else begin
			valid_o <= accept & hit_any;
			hit_o <= accept & hit_any;
			miss_o <= accept & ~hit_any;
			touch_o <= accept & hit_any;
		end
	end

	always_ff @(posedge clk) begin
		data_o <= hit_word;
		miss_req_o <= fetch_req_i;
		touch_way_o <= hit_way;
	end

endmodule

/* hw/cache_lru.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_lru import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic touch_i,
	input way_t touch_way_i,
	input index_t touch_index_i,
	input tag_wr_t wr_i,
	input index_t victim_index_i,
	output way_t victim_o
);

	// Bit 0 picks the pair, bit 1 the way in pair 0-1, bit 2 the way in pair 2-3
	logic [2:0] tree [`CACHE_LINES];
	logic [2:0] victim_tree;

	// Point every node on the path away from the way just used
	function automatic logic [2:0] touch_tree(logic [2:0] cur, way_t w);
		logic [2:0] nxt;
		nxt = cur;
		nxt[0] = ~w[1];
		if (w[1]) begin
			nxt[2] = ~w[0];
		end else begin
			nxt[1] = ~w[0];
		end
		return nxt;
	endfunction

	// Invalidations leave the replacement order alone
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				tree[i] <= '0;
			end
		end else begin
			if (touch_i) begin
				tree[touch_index_i] <= touch_tree(tree[touch_index_i], touch_way_i);
			end
			if (wr_i.en && wr_i.kind == TAG_FILL) begin
				tree[wr_i.index] <= touch_tree(tree[wr_i.index], wr_i.way);
			end
		end
	end

	// Follow the tree bits down to the least recently used way
	assign victim_tree = tree[victim_index_i];
	assign victim_o = victim_tree[0] ? {1'b1, victim_tree[2]} : {1'b0, victim_tree[1]};

endmodule

/* hw/cache_pkg.sv */
package cache_pkg;

	// ======================================================================
	// Basic address and storage types
	// ======================================================================

	typedef logic [31:0] address_t;

	// Tag field covers address bits 31 down to 10
	typedef logic [31:10] cache_tag_t;

	typedef logic [5:0] index_t;
	typedef logic [1:0] way_t;

	// Four 32-bit words, word 0 sits in the low bits
	typedef logic [127:0] line_t;

	// Fetch request carries both translations of the same address
	typedef struct packed {
		address_t vadr;
		address_t padr;
	} fetch_req_t;

	// A fill writes real tags, an invalidate writes the empty marker
	typedef enum logic {
		TAG_FILL = 1'b0,
		TAG_INVALIDATE = 1'b1
	} tag_kind_e;

	// One request on the shared tag write port
	typedef struct packed {
		logic en;
		tag_kind_e kind;
		way_t way;
		index_t index;
		cache_tag_t vtag;
		cache_tag_t ptag;
	} tag_wr_t;

	// Set index of a byte address, bits 9 down to 4
	function automatic index_t adr_index(address_t adr);
		return adr[9:4];
	endfunction

endpackage

/* hw/cache_snoop.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_snoop import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic snoop_i,
	input address_t snoop_adr_i,
	input cache_tag_t [`CACHE_WAYS-1:0] ptags_i,
	input logic grant_i,
	output index_t snoop_index_o,
	output tag_wr_t wr_req_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_COMPARE,
		S_INVAL
	} state_e;

	state_e state;
	address_t adr_q;
	cache_tag_t snoop_tag;
	logic [`CACHE_WAYS-1:0] match_now;
	logic [`CACHE_WAYS-1:0] match_q;
	logic [`CACHE_WAYS-1:0] remaining;
	way_t inv_way;

	assign snoop_tag = adr_q[31:`CACHE_TAGBIT];
	assign snoop_index_o = adr_q[`CACHE_HIBIT:`CACHE_LOBIT];

	// Physical tags at the snoop set, compared one cycle after capture
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match_now[w] = (ptags_i[w] == snoop_tag);
		end
	end

	// Lowest matching way goes first
	always_comb begin
		inv_way = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (match_q[w]) begin
				inv_way = way_t'(w);
			end
		end
	end

	assign remaining = match_q & ~(`CACHE_WAYS'(1) << inv_way);

	// New snoops are ignored until every match has been invalidated
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			match_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (snoop_i) begin
						state <= S_COMPARE;
					end
				end
				S_COMPARE: begin
					match_q <= match_now;
					state <= (|match_now) ? S_INVAL : S_IDLE;
				end
				S_INVAL: begin
					if (grant_i) begin
						match_q <= remaining;
						if (remaining == '0) begin
							state <= S_IDLE;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && snoop_i) begin
			adr_q <= snoop_adr_i;
		end
	end

	// The request stays up until the arbiter grants it
	always_comb begin
		wr_req_o = '0;
		wr_req_o.en = (state == S_INVAL);
		wr_req_o.kind = TAG_INVALIDATE;
		wr_req_o.way = inv_way;
		wr_req_o.index = snoop_index_o;
		wr_req_o.vtag = snoop_tag;
		wr_req_o.ptag = snoop_tag;
	end

endmodule

/* hw/cache_tag.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tag import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input index_t lookup_index_i,
	input index_t snoop_index_i,
	input tag_wr_t wr_i,
	output cache_tag_t [`CACHE_WAYS-1:0] vtags_o,
	output cache_tag_t [`CACHE_WAYS-1:0] ptags_o
);

	// ======================================================================
	// Tag storage
	// ======================================================================

	// Small arrays meant for distributed RAM, one column per way
	cache_tag_t vtags [`CACHE_WAYS][`CACHE_LINES];
	cache_tag_t ptags [`CACHE_WAYS][`CACHE_LINES];

	// High from reset until the sweep has written the last set
	logic sweep_q;

	cache_tag_t wr_vtag;
	cache_tag_t wr_ptag;

	// Invalidations store the empty marker in both arrays
	always_comb begin
		if (wr_i.kind == TAG_INVALIDATE) begin
			wr_vtag = cache_tag_t'(`CACHE_INVALID_TAG);
			wr_ptag = cache_tag_t'(`CACHE_INVALID_TAG);
		end else begin
			wr_vtag = wr_i.vtag;
			wr_ptag = wr_i.ptag;
		end
	end

	// The start-up sweep walks the sets once and ends on the top index
	always_ff @(posedge clk) begin
		if (rst) begin
			sweep_q <= 1'b1;
		end else if (wr_i.en && wr_i.index == index_t'(`CACHE_LINES - 1)) begin
			sweep_q <= 1'b0;
		end
	end

	// While sweeping, one write clears the set in every way at once
	always_ff @(posedge clk) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (wr_i.en && (sweep_q || wr_i.way == way_t'(w))) begin
				vtags[w][wr_i.index] <= wr_vtag;
				ptags[w][wr_i.index] <= wr_ptag;
			end
		end
	end

	// ======================================================================
	// Read ports
	// ======================================================================

	// Lookup reads virtual tags, snoop reads physical tags, both at once
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			vtags_o[w] = vtags[w][lookup_index_i];
			ptags_o[w] = ptags[w][snoop_index_i];
		end
	end

endmodule

/* hw/icache_top.sv */
`timescale 1ns/10ps

module icache_top import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch_i,
	input fetch_req_t fetch_req_i,
	output logic valid_o,
	output logic [31:0] data_o,
	output logic hit_o,
	output logic busy_o,
	input logic snoop_i,
	input address_t snoop_adr_i,
	output logic mem_req_o,
	output address_t mem_adr_o,
	input logic mem_ack_i,
	input line_t mem_line_i
);

	// ======================================================================
	// Internal wiring
	// ======================================================================

	index_t lookup_index;
	index_t snoop_index;
	index_t miss_index;
	cache_tag_t [3:0] vtags;
	cache_tag_t [3:0] ptags;
	line_t [3:0] lines;
	tag_wr_t fill_req;
	tag_wr_t snoop_req;
	tag_wr_t tag_wr;
	logic fill_grant;
	logic snoop_grant;
	logic lk_valid;
	logic [31:0] lk_data;
	logic miss;
	fetch_req_t miss_req;
	logic touch;
	way_t touch_way;
	way_t victim;
	logic data_wr;
	way_t data_way;
	index_t data_index;
	line_t data_line;
	logic fill_valid;
	logic [31:0] fill_data;

	assign lookup_index = adr_index(fetch_req_i.vadr);
	assign miss_index = adr_index(miss_req.vadr);

	cache_tag u_tag (
		.clk(clk), .rst(rst),
		.lookup_index_i(lookup_index), .snoop_index_i(snoop_index),
		.wr_i(tag_wr), .vtags_o(vtags), .ptags_o(ptags)
	);

	cache_data u_data (
		.clk(clk), .rd_index_i(lookup_index),
		.wr_i(data_wr), .wr_way_i(data_way), .wr_index_i(data_index),
		.wr_line_i(data_line), .lines_o(lines)
	);

	cache_lookup u_lookup (
		.clk(clk), .rst(rst), .fetch_i(fetch_i), .fetch_req_i(fetch_req_i),
		.busy_i(busy_o), .vtags_i(vtags), .line_i(lines),
		.valid_o(lk_valid), .hit_o(hit_o), .data_o(lk_data),
		.miss_o(miss), .miss_req_o(miss_req),
		.touch_o(touch), .touch_way_o(touch_way)
	);

	// Hit touches and the victim both refer to the set of the last fetch
	cache_lru u_lru (
		.clk(clk), .rst(rst), .touch_i(touch), .touch_way_i(touch_way),
		.touch_index_i(miss_index), .wr_i(tag_wr),
		.victim_index_i(miss_index), .victim_o(victim)
	);

	cache_fill u_fill (
		.clk(clk), .rst(rst), .miss_i(miss), .miss_req_i(miss_req),
		.victim_i(victim), .grant_i(fill_grant),
		.mem_ack_i(mem_ack_i), .mem_line_i(mem_line_i),
		.busy_o(busy_o), .wr_req_o(fill_req),
		.mem_req_o(mem_req_o), .mem_adr_o(mem_adr_o),
		.data_wr_o(data_wr), .data_way_o(data_way), .data_index_o(data_index),
		.data_line_o(data_line), .valid_o(fill_valid), .data_o(fill_data)
	);

	cache_snoop u_snoop (
		.clk(clk), .rst(rst), .snoop_i(snoop_i), .snoop_adr_i(snoop_adr_i),
		.ptags_i(ptags), .grant_i(snoop_grant),
		.snoop_index_o(snoop_index), .wr_req_o(snoop_req)
	);

	tag_write_arbiter u_arb (
		.fill_req_i(fill_req), .snoop_req_i(snoop_req),
		.fill_grant_o(fill_grant), .snoop_grant_o(snoop_grant), .wr_o(tag_wr)
	);

	// Lookup and fill never return a word in the same cycle
	assign valid_o = lk_valid | fill_valid;
	assign data_o = lk_valid ? lk_data : fill_data;

endmodule

/* hw/tag_write_arbiter.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module tag_write_arbiter import cache_pkg::*; (
	input tag_wr_t fill_req_i,
	input tag_wr_t snoop_req_i,
	output logic fill_grant_o,
	output logic snoop_grant_o,
	output tag_wr_t wr_o
);

	// Fill has fixed priority, a snoop only writes when fill is quiet
	assign fill_grant_o = fill_req_i.en;
	assign snoop_grant_o = snoop_req_i.en & ~fill_req_i.en;

	// With no request the snoop side carries en low, so the port is idle
	always_comb begin
		if (fill_req_i.en) begin
			wr_o = fill_req_i;
		end else begin
			wr_o = snoop_req_i;
		end
	end

endmodule

/* icache_top.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_tag.sv
hw/cache_lookup.sv
hw/cache_data.sv
hw/cache_lru.sv
hw/cache_fill.sv
hw/cache_snoop.sv
hw/tag_write_arbiter.sv
hw/icache_top.sv
verif/tb_icache.sv

/* verif/cache_trace.txt */
# kind vadr padr hit data, F is a fetch, S a snoop of padr, W waits vadr cycles
# hit and data are the expected fetch result, unused columns hold zero
F 00012340 80012340 0 7FFE2340
F 00012340 80012340 1 7FFE2340
F 0001234C 8001234C 1 7FFE234C
F 00020050 80020050 0 7FFD0050
F 00030054 80030054 0 7FFC0054
F 00040058 80040058 0 7FFB0058
F 0005005C 8005005C 0 7FFA005C
F 00060050 80060050 0 7FF90050
F 00060054 80060054 1 7FF90054
F 00020050 80020050 0 7FFD0050
F 00040058 80040058 1 7FFB0058
S 00000000 80012340 0 00000000
W 00000004 00000000 0 00000000
F 00012340 80012340 0 7FFE2340
F 00012344 80012344 1 7FFE2344
S 00000000 80099340 0 00000000
W 00000004 00000000 0 00000000
F 00012348 80012348 1 7FFE2348
F 000300A8 800300A8 0 7FFC00A8
F 000303F4 800303F4 0 7FFC03F4
F 00100000 80100000 0 7FEF0000
F 000300A0 800300A0 1 7FFC00A0
F 000303F0 800303F0 1 7FFC03F0
F 00100008 80100008 1 7FEF0008
F 00060050 80060050 1 7FF90050

/* verif/tb_icache.sv */
`timescale 1ns/10ps

module tb_icache import cache_pkg::*; ();

	localparam int SWEEP_CYCLES = 64;
	localparam int SWEEP_LIMIT = 200;
	localparam int BUSY_LIMIT = 100;
	localparam int VALID_LIMIT = 40;
	localparam string TRACE_FILE = "verif/cache_trace.txt";

	logic clk;
	logic rst;
	logic fetch_i;
	fetch_req_t fetch_req_i;
	logic valid_o;
	logic [31:0] data_o;
	logic hit_o;
	logic busy_o;
	logic snoop_i;
	address_t snoop_adr_i;
	logic mem_req_o;
	address_t mem_adr_o;
	logic mem_ack_i;
	line_t mem_line_i;

	int error_count = 0;
	int timeout_count = 0;
	int mem_req_count = 0;
	// Line address the memory model expects for the fetch in flight
	address_t exp_line_adr = '0;

	icache_top DUT (
		.clk(clk), .rst(rst),
		.fetch_i(fetch_i), .fetch_req_i(fetch_req_i),
		.valid_o(valid_o), .data_o(data_o), .hit_o(hit_o), .busy_o(busy_o),
		.snoop_i(snoop_i), .snoop_adr_i(snoop_adr_i),
		.mem_req_o(mem_req_o), .mem_adr_o(mem_adr_o),
		.mem_ack_i(mem_ack_i), .mem_line_i(mem_line_i)
	);

	// 20 ns clock period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==========================================================================
	// Memory model
	// ==========================================================================

	// Each word holds its own byte address with the upper half inverted
	function automatic logic [31:0] mem_word(address_t adr);
		return {~adr[31:16], adr[15:0]};
	endfunction

	function automatic line_t mem_line(address_t line_adr);
		line_t line;
		line = '0;
		for (int i = 0; i < 4; i++) begin
			line[i*32 +: 32] = mem_word(line_adr + address_t'(i * 4));
		end
		return line;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		error_count++;
	endtask

	// Answers every request after 2 to 9 cycles with a single acknowledge pulse
	initial begin : memory_model
		int delay;
		void'($urandom(56));
		mem_ack_i = 1'b0;
		mem_line_i = '0;
		forever begin
			@(negedge clk);
			if (mem_req_o === 1'b1) begin
				mem_req_count++;
				if (mem_adr_o !== exp_line_adr) begin
					report_mismatch("mem_adr_o", exp_line_adr, mem_adr_o);
				end
				delay = 2 + int'($urandom % 8);
				repeat (delay) @(posedge clk);
				mem_ack_i <= 1'b1;
				mem_line_i <= mem_line(mem_adr_o);
				@(posedge clk);
				mem_ack_i <= 1'b0;
			end
		end
	end

	// ==========================================================================
	// Bounded waits
	// ==========================================================================

	// The start-up sweep keeps busy_o high for one cycle per set and raises no output
	task automatic check_sweep(output bit ok);
		int busy_cycles;
		bit done;
		busy_cycles = 0;
		done = 1'b0;
		ok = 1'b1;
		while (!done) begin
			@(negedge clk);
			if (valid_o !== 1'b0) begin
				report_mismatch("valid_o", 32'd0, 32'(valid_o));
			end
			if (mem_req_o !== 1'b0) begin
				report_mismatch("mem_req_o", 32'd0, 32'(mem_req_o));
			end
			if (busy_o === 1'b1) begin
				busy_cycles++;
				if (busy_cycles > SWEEP_LIMIT) begin
					$display("TIMEOUT at %0d ns: busy_o never fell after reset", $time);
					timeout_count++;
					ok = 1'b0;
					done = 1'b1;
				end
			end else begin
				done = 1'b1;
			end
		end
		if (ok && busy_cycles != SWEEP_CYCLES) begin
			report_mismatch("busy_o high cycles", 32'(SWEEP_CYCLES), 32'(busy_cycles));
		end
	endtask

	task automatic wait_busy_low(output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (ok && busy_o !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > BUSY_LIMIT) begin
				$display("TIMEOUT at %0d ns: busy_o stayed high for %0d cycles", $time, cycles);
				timeout_count++;
				ok = 1'b0;
			end
		end
	endtask

	// Counts the cycles from the sampling edge of fetch_i to valid_o
	task automatic wait_valid(output int cycles, output bit ok);
		bit done;
		cycles = 0;
		ok = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (valid_o === 1'b1) begin
				ok = 1'b1;
				done = 1'b1;
			end else if (cycles >= VALID_LIMIT) begin
				$display("TIMEOUT at %0d ns: no valid_o after a fetch", $time);
				timeout_count++;
				done = 1'b1;
			end
		end
	endtask

	// ==========================================================================
	// Trace records
	// ==========================================================================

	task automatic do_fetch(input address_t vadr, input address_t padr, input logic exp_hit,
			input logic [31:0] exp_data);
		int cycles;
		int req_before;
		bit ok;
		cycles = 0;
		wait_busy_low(ok);
		if (ok) begin
			// Lines are 16 bytes, so the request address has its low nibble cleared
			exp_line_adr = {padr[31:4], 4'h0};
			req_before = mem_req_count;
			@(posedge clk);
			fetch_i <= 1'b1;
			fetch_req_i.vadr <= vadr;
			fetch_req_i.padr <= padr;
			@(posedge clk);
			fetch_i <= 1'b0;
			wait_valid(cycles, ok);
		end
		if (ok) begin
			if (hit_o !== exp_hit) begin
				report_mismatch("hit_o", 32'(exp_hit), 32'(hit_o));
			end
			if (data_o !== exp_data) begin
				report_mismatch("data_o", exp_data, data_o);
			end
			if (exp_hit && cycles != 1) begin
				report_error($sformatf("hit answered %0d cycles after the fetch, not 1",
					cycles));
			end
			// On a miss busy_o drops in the same cycle as the returned word
			if (busy_o !== 1'b0) begin
				report_mismatch("busy_o", 32'd0, 32'(busy_o));
			end
			@(negedge clk);
			if (valid_o !== 1'b0) begin
				report_mismatch("valid_o", 32'd0, 32'(valid_o));
			end
			// One more cycle lets a late memory request reach the count
			@(negedge clk);
			if (mem_req_count - req_before != (exp_hit ? 0 : 1)) begin
				report_mismatch("mem_req_o pulses", exp_hit ? 32'd0 : 32'd1,
					32'(mem_req_count - req_before));
			end
		end
	endtask

	task automatic do_snoop(input address_t adr);
		@(posedge clk);
		snoop_i <= 1'b1;
		snoop_adr_i <= adr;
		@(posedge clk);
		snoop_i <= 1'b0;
		@(negedge clk);
	endtask

	initial begin : main_flow
		int fd;
		int line_len;
		int fields;
		int record_count;
		bit ok;
		logic [8*128-1:0] line_buf;
		logic [7:0] kind;
		logic [31:0] f_vadr;
		logic [31:0] f_padr;
		logic [31:0] f_hit;
		logic [31:0] f_data;
		record_count = 0;
		rst = 1'b1;
		fetch_i = 1'b0;
		fetch_req_i = '0;
		snoop_i = 1'b0;
		snoop_adr_i = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		check_sweep(ok);
		if (ok) begin
			fd = $fopen(TRACE_FILE, "r");
			if (fd == 0) begin
				report_error("cannot open the trace file");
			end else begin
				// Comment lines fail the five-field match and are skipped
				while (timeout_count == 0 && !$feof(fd)) begin
					line_buf = '0;
					fields = 0;
					line_len = $fgets(line_buf, fd);
					if (line_len > 0) begin
						fields = $sscanf(line_buf, "%s %h %h %h %h",
							kind, f_vadr, f_padr, f_hit, f_data);
					end
					if (fields == 5) begin
						record_count++;
						case (kind)
							"F": do_fetch(f_vadr, f_padr, f_hit[0], f_data);
							"S": do_snoop(f_padr);
							"W": repeat (f_vadr) @(negedge clk);
							default: report_error($sformatf("unknown record kind %c", kind));
						endcase
					end
				end
				$fclose(fd);
				if (record_count == 0) begin
					report_error("the trace file holds no records");
				end
			end
		end
		$display("Records: %0d, errors: %0d, timeouts: %0d",
			record_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
